/* rtl/bus_pkg.sv */
package bus_pkg;

  // Word address on both buses
  localparam int ADDR_W = 25;

  typedef logic [ADDR_W-1:0] adr_t;

  // Stored with every queued request
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } req_op_e;

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_READ_WAIT,
    PORT_DONE
  } port_state_e;

endpackage

/* rtl/cache_pkg.sv */
package cache_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  sel_t;

  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_IDX_W     = $clog2(WORDS_PER_LINE);
  localparam int LINE_DATA_W    = WORDS_PER_LINE * $bits(word_t);

  // Row layout from the top bit down: valid, dirty per word, tag, word3 .. word0
  function automatic int row_width(input int tag_w);
    return 1 + WORDS_PER_LINE + tag_w + LINE_DATA_W;
  endfunction

  typedef enum logic [3:0] {
    INIT,
    IDLE,
    LOOKUP,
    COMPARE,
    HIT,
    COMMIT,
    FLUSH_REQ,
    FLUSH_NEXT,
    FILL_REQ,
    FILL_NEXT,
    FILL_WRITE,
    FLUSH_WRITE
  } ctrl_state_e;

endpackage

/* rtl/req_fifo.sv */
`timescale 1ns/10ps

module req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              push_i,
  input  logic              pop_i,
  input  bus_pkg::req_op_e  op_i,
  input  bus_pkg::adr_t     adr_i,
  input  cache_pkg::word_t  dat_i,
  input  cache_pkg::sel_t   sel_i,
  output bus_pkg::req_op_e  op_o,
  output bus_pkg::adr_t     adr_o,
  output cache_pkg::word_t  dat_o,
  output cache_pkg::sel_t   sel_o,
  output logic              full_o,
  output logic              empty_o
);
  import bus_pkg::*;
  import cache_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  req_op_e          op_mem  [FIFO_DEPTH];
  adr_t             adr_mem [FIFO_DEPTH];
  word_t            dat_mem [FIFO_DEPTH];
  sel_t             sel_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      op_mem[wr_ptr_q]  <= op_i;
      adr_mem[wr_ptr_q] <= adr_i;
      dat_mem[wr_ptr_q] <= dat_i;
      sel_mem[wr_ptr_q] <= sel_i;
    end
  end

  // Popped entry stays on the outputs while the controller serves it
  always_ff @(posedge clk_i) begin
    if (do_pop) begin
      op_o  <= op_mem[rd_ptr_q];
      adr_o <= adr_mem[rd_ptr_q];
      dat_o <= dat_mem[rd_ptr_q];
      sel_o <= sel_mem[rd_ptr_q];
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* rtl/line_ram.sv */
`timescale 1ns/10ps

module line_ram #(
  parameter int  ROW_BITS = 6,
  localparam int TAG_W    = bus_pkg::ADDR_W - ROW_BITS - cache_pkg::WORD_IDX_W,
  localparam int ROW_W    = cache_pkg::row_width(TAG_W)
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [ROW_BITS-1:0] addr_i,
  input  logic                we_i,
  input  logic [ROW_W-1:0]    row_dat_i,
  output logic [ROW_W-1:0]    row_dat_o
);

  logic [ROW_W-1:0] mem_q [2**ROW_BITS];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= row_dat_i;
    end
  end

  // Registered read port, data follows the address by one cycle
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      row_dat_o <= '0;
    end else begin
      row_dat_o <= mem_q[addr_i];
    end
  end

endmodule

/* rtl/line_merge.sv */
`timescale 1ns/10ps

module line_merge #(
  parameter int  ROW_BITS = 6,
  localparam int TAG_W    = bus_pkg::ADDR_W - ROW_BITS - cache_pkg::WORD_IDX_W,
  localparam int ROW_W    = cache_pkg::row_width(TAG_W)
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [ROW_W-1:0]                     row_i,
  input  logic                                 load_i,
  input  logic                                 merge_i,
  input  logic                                 fill_i,
  input  logic                                 clean_i,
  input  logic                                 set_tag_i,
  input  logic [cache_pkg::WORD_IDX_W-1:0]     word_idx_i,
  input  logic [TAG_W-1:0]                     tag_i,
  input  cache_pkg::word_t                     dat_i,
  input  cache_pkg::sel_t                      sel_i,
  input  cache_pkg::word_t                     mem_dat_i,
  output logic [ROW_W-1:0]                     row_o,
  output logic [TAG_W-1:0]                     tag_o,
  output logic                                 valid_o,
  output logic [cache_pkg::WORDS_PER_LINE-1:0] dirty_o,
  output cache_pkg::word_t                     word_o
);
  import cache_pkg::*;

  localparam int WORD_W    = $bits(word_t);
  localparam int DIRTY_LSB = LINE_DATA_W + TAG_W;
  localparam int VALID_BIT = ROW_W - 1;

  logic [ROW_W-1:0] line_q;
  logic [ROW_W-1:0] line_d;
  logic [ROW_W-1:0] view;
  word_t            cur_word;
  word_t            merged;

  // While loading, the status comes straight from the row memory for the tag compare
  assign view    = load_i ? row_i : line_q;
  assign tag_o   = view[LINE_DATA_W +: TAG_W];
  assign dirty_o = view[DIRTY_LSB +: WORDS_PER_LINE];
  assign valid_o = view[VALID_BIT];
  assign row_o   = line_q;

  assign cur_word = line_q[word_idx_i * WORD_W +: WORD_W];

  always_comb begin
    for (int b = 0; b < $bits(sel_t); b++) begin
      merged[b * 8 +: 8] = sel_i[b] ? dat_i[b * 8 +: 8] : cur_word[b * 8 +: 8];
    end
  end

  always_comb begin
    line_d = line_q;
    if (load_i) begin
      line_d = row_i;
    end
    if (merge_i) begin
      line_d[word_idx_i * WORD_W +: WORD_W] = merged;
      line_d[DIRTY_LSB + word_idx_i]        = 1'b1;
    end
    if (fill_i) begin
      line_d[word_idx_i * WORD_W +: WORD_W] = mem_dat_i;
      line_d[DIRTY_LSB + word_idx_i]        = 1'b0;
    end
    if (clean_i) begin
      line_d[DIRTY_LSB + word_idx_i] = 1'b0;
    end
    if (set_tag_i) begin
      line_d[LINE_DATA_W +: TAG_W] = tag_i;
      line_d[VALID_BIT]            = 1'b1;
    end
  end

  // word_o is both the read result and the write-back data
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      line_q <= '0;
      word_o <= '0;
    end else begin
      line_q <= line_d;
      word_o <= cur_word;
    end
  end

endmodule

/* rtl/slave_port.sv */
`timescale 1ns/10ps

module slave_port (
  input  logic clk_i,
  input  logic rst_i,
  input  logic s_cyc_i,
  input  logic s_stb_i,
  input  logic s_we_i,
  input  logic fifo_full_i,
  input  logic fifo_empty_i,
  input  logic commit_i,
  output logic fifo_push_o,
  output logic s_ack_o
);
  import bus_pkg::*;

  port_state_e state_q;
  port_state_e state_d;
  logic        take;

  assign take        = (state_q == PORT_IDLE) && s_cyc_i && s_stb_i && !fifo_full_i;
  assign fifo_push_o = take;
  assign s_ack_o     = (state_q == PORT_DONE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      PORT_IDLE: begin
        if (take) begin
          state_d = s_we_i ? PORT_DONE : PORT_READ_WAIT;
        end
      end
      // Read finishes only when nothing is queued ahead of it
      PORT_READ_WAIT: begin
        if (fifo_empty_i && commit_i) begin
          state_d = PORT_DONE;
        end
      end
      PORT_DONE: state_d = PORT_IDLE;
      default:   state_d = PORT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= PORT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* rtl/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl #(
  parameter int  ROW_BITS = 6,
  localparam int TAG_W    = bus_pkg::ADDR_W - ROW_BITS - cache_pkg::WORD_IDX_W
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 fifo_empty_i,
  output logic                                 fifo_pop_o,
  input  bus_pkg::req_op_e                     head_op_i,
  input  bus_pkg::adr_t                        head_adr_i,
  input  logic [TAG_W-1:0]                     tag_i,
  input  logic                                 valid_i,
  input  logic [cache_pkg::WORDS_PER_LINE-1:0] dirty_i,
  output logic [ROW_BITS-1:0]                  ram_addr_o,
  output logic                                 ram_we_o,
  output logic                                 load_o,
  output logic                                 merge_o,
  output logic                                 fill_o,
  output logic                                 clean_o,
  output logic                                 set_tag_o,
  output logic [cache_pkg::WORD_IDX_W-1:0]     word_idx_o,
  output logic [TAG_W-1:0]                     tag_o,
  output logic                                 commit_o,
  output logic                                 m_cyc_o,
  output logic                                 m_stb_o,
  output logic                                 m_we_o,
  output bus_pkg::adr_t                        m_adr_o,
  input  logic                                 m_ack_i
);
  import bus_pkg::*;
  import cache_pkg::*;

  ctrl_state_e           state_q;
  ctrl_state_e           state_d;
  logic [ROW_BITS-1:0]   init_q;
  logic [ROW_BITS-1:0]   init_d;
  logic [WORD_IDX_W-1:0] wcnt_q;
  logic [WORD_IDX_W-1:0] wcnt_d;
  logic [TAG_W-1:0]      req_tag;
  logic [ROW_BITS-1:0]   req_row;
  logic [WORD_IDX_W-1:0] req_word;
  logic                  is_write;
  logic                  hit;
  logic                  last_word;

  assign {req_tag, req_row, req_word} = head_adr_i;

  assign is_write   = (head_op_i == OP_WRITE);
  assign hit        = valid_i && (tag_i == req_tag);
  assign last_word  = (wcnt_q == WORD_IDX_W'(WORDS_PER_LINE - 1));
  assign tag_o      = req_tag;
  assign ram_addr_o = (state_q == INIT) ? init_q : req_row;
  assign fifo_pop_o = (state_q == IDLE) && !fifo_empty_i;
  assign commit_o   = (state_q == COMMIT);

  // Line transfers walk the word counter, everything else uses the request word
  assign word_idx_o = (state_q inside {FLUSH_NEXT, FLUSH_REQ, FILL_REQ, FILL_NEXT}) ?
                      wcnt_q : req_word;

  assign m_stb_o = m_cyc_o;

  always_comb begin
    m_cyc_o = 1'b0;
    m_we_o  = 1'b0;
    m_adr_o = '0;
    case (state_q)
      // Old tag still sits in the row image during write-back
      FLUSH_REQ: begin
        m_cyc_o = 1'b1;
        m_we_o  = 1'b1;
        m_adr_o = {tag_i, req_row, wcnt_q};
      end
      FILL_REQ: begin
        m_cyc_o = 1'b1;
        m_adr_o = {req_tag, req_row, wcnt_q};
      end
      default: begin
        m_cyc_o = 1'b0;
      end
    endcase
  end

  always_comb begin
    state_d   = state_q;
    init_d    = init_q;
    wcnt_d    = wcnt_q;
    ram_we_o  = 1'b0;
    load_o    = 1'b0;
    merge_o   = 1'b0;
    fill_o    = 1'b0;
    clean_o   = 1'b0;
    set_tag_o = 1'b0;
    case (state_q)
      // One row cleared per cycle
      INIT: begin
        ram_we_o = 1'b1;
        init_d   = init_q + 1'b1;
        if (&init_q) begin
          state_d = IDLE;
        end
      end
      IDLE: begin
        if (!fifo_empty_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: state_d = COMPARE;
      COMPARE: begin
        load_o = 1'b1;
        wcnt_d = '0;
        if (hit) begin
          state_d = HIT;
        end else if (valid_i && |dirty_i) begin
          state_d = FLUSH_NEXT;
        end else begin
          state_d = FILL_REQ;
        end
      end
      HIT: begin
        merge_o = is_write;
        state_d = COMMIT;
      end
      COMMIT: begin
        ram_we_o = is_write;
        state_d  = IDLE;
      end
      // Skip clean words
      FLUSH_NEXT: begin
        if (dirty_i[wcnt_q]) begin
          state_d = FLUSH_REQ;
        end else if (last_word) begin
          state_d = FLUSH_WRITE;
        end else begin
          wcnt_d = wcnt_q + 1'b1;
        end
      end
      FLUSH_REQ: begin
        if (m_ack_i) begin
          clean_o = 1'b1;
          if (last_word) begin
            state_d = FLUSH_WRITE;
          end else begin
            wcnt_d  = wcnt_q + 1'b1;
            state_d = FLUSH_NEXT;
          end
        end
      end
      FLUSH_WRITE: begin
        ram_we_o = 1'b1;
        wcnt_d   = '0;
        state_d  = FILL_REQ;
      end
      FILL_REQ: begin
        if (m_ack_i) begin
          fill_o  = 1'b1;
          state_d = FILL_NEXT;
        end
      end
      FILL_NEXT: begin
        if (last_word) begin
          set_tag_o = 1'b1;
          state_d   = FILL_WRITE;
        end else begin
          wcnt_d  = wcnt_q + 1'b1;
          state_d = FILL_REQ;
        end
      end
      // Row now holds the new line, so the retry will hit
      FILL_WRITE: begin
        ram_we_o = 1'b1;
        state_d  = LOOKUP;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= INIT;
      init_q  <= '0;
      wcnt_q  <= '0;
    end else begin
      state_q <= state_d;
      init_q  <= init_d;
      wcnt_q  <= wcnt_d;
    end
  end

endmodule

/* rtl/cache_top.sv */
`timescale 1ns/10ps

module cache_top #(
  parameter int ROW_BITS   = 6,
  parameter int FIFO_DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             s_cyc_i,
  input  logic             s_stb_i,
  input  logic             s_we_i,
  input  bus_pkg::adr_t    s_adr_i,
  input  cache_pkg::sel_t  s_sel_i,
  input  cache_pkg::word_t s_dat_i,
  output cache_pkg::word_t s_dat_o,
  output logic             s_ack_o,
  output logic             m_cyc_o,
  output logic             m_stb_o,
  output logic             m_we_o,
  output bus_pkg::adr_t    m_adr_o,
  output cache_pkg::word_t m_dat_o,
  input  cache_pkg::word_t m_dat_i,
  input  logic             m_ack_i
);
  import bus_pkg::*;
  import cache_pkg::*;

  localparam int TAG_W = ADDR_W - ROW_BITS - WORD_IDX_W;
  localparam int ROW_W = row_width(TAG_W);

  logic                      fifo_push;
  logic                      fifo_pop;
  logic                      fifo_full;
  logic                      fifo_empty;
  logic                      commit;
  req_op_e                   head_op;
  adr_t                      head_adr;
  word_t                     head_dat;
  sel_t                      head_sel;
  logic [TAG_W-1:0]          line_tag;
  logic [TAG_W-1:0]          req_tag;
  logic                      line_valid;
  logic [WORDS_PER_LINE-1:0] line_dirty;
  logic [ROW_BITS-1:0]       ram_addr;
  logic                      ram_we;
  logic                      load;
  logic                      merge;
  logic                      fill;
  logic                      clean;
  logic                      set_tag;
  logic [WORD_IDX_W-1:0]     word_idx;
  logic [ROW_W-1:0]          ram_row;
  logic [ROW_W-1:0]          image_row;
  word_t                     line_word;

  // Same register feeds the read data and the write-back data
  assign s_dat_o = line_word;
  assign m_dat_o = line_word;

  slave_port u_slave_port (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .s_cyc_i      (s_cyc_i),
    .s_stb_i      (s_stb_i),
    .s_we_i       (s_we_i),
    .fifo_full_i  (fifo_full),
    .fifo_empty_i (fifo_empty),
    .commit_i     (commit),
    .fifo_push_o  (fifo_push),
    .s_ack_o      (s_ack_o)
  );

  req_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_req_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (fifo_push),
    .pop_i   (fifo_pop),
    .op_i    (req_op_e'(s_we_i)),
    .adr_i   (s_adr_i),
    .dat_i   (s_dat_i),
    .sel_i   (s_sel_i),
    .op_o    (head_op),
    .adr_o   (head_adr),
    .dat_o   (head_dat),
    .sel_o   (head_sel),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  cache_ctrl #(
    .ROW_BITS (ROW_BITS)
  ) u_cache_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .fifo_empty_i (fifo_empty),
    .fifo_pop_o   (fifo_pop),
    .head_op_i    (head_op),
    .head_adr_i   (head_adr),
    .tag_i        (line_tag),
    .valid_i      (line_valid),
    .dirty_i      (line_dirty),
    .ram_addr_o   (ram_addr),
    .ram_we_o     (ram_we),
    .load_o       (load),
    .merge_o      (merge),
    .fill_o       (fill),
    .clean_o      (clean),
    .set_tag_o    (set_tag),
    .word_idx_o   (word_idx),
    .tag_o        (req_tag),
    .commit_o     (commit),
    .m_cyc_o      (m_cyc_o),
    .m_stb_o      (m_stb_o),
    .m_we_o       (m_we_o),
    .m_adr_o      (m_adr_o),
    .m_ack_i      (m_ack_i)
  );

  line_merge #(
    .ROW_BITS (ROW_BITS)
  ) u_line_merge (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .row_i      (ram_row),
    .load_i     (load),
    .merge_i    (merge),
    .fill_i     (fill),
    .clean_i    (clean),
    .set_tag_i  (set_tag),
    .word_idx_i (word_idx),
    .tag_i      (req_tag),
    .dat_i      (head_dat),
    .sel_i      (head_sel),
    .mem_dat_i  (m_dat_i),
    .row_o      (image_row),
    .tag_o      (line_tag),
    .valid_o    (line_valid),
    .dirty_o    (line_dirty),
    .word_o     (line_word)
  );

  line_ram #(
    .ROW_BITS (ROW_BITS)
  ) u_line_ram (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .addr_i    (ram_addr),
    .we_i      (ram_we),
    .row_dat_i (image_row),
    .row_dat_o (ram_row)
  );

endmodule

/* testbench/cache_checker.sv */
`timescale 1ns/10ps

module cache_checker (
  input logic             clk_i,
  input logic             rst_i,
  input logic             m_cyc_i,
  input logic             m_stb_i,
  input logic             m_we_i,
  input bus_pkg::adr_t    m_adr_i,
  input cache_pkg::word_t m_wdat_i,
  input logic             m_ack_i,
  input logic             s_ack_i
);

  // Read by the testbench once per cycle
  int fail_count = 0;

  stb_matches_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    m_stb_i == m_cyc_i)
    else begin
      fail_count++;
      $error("m_stb_o differs from m_cyc_o");
    end

  // Master request held until memory acks
  master_held: assert property (@(posedge clk_i) disable iff (rst_i)
    m_cyc_i && !m_ack_i |=> m_cyc_i && $stable(m_we_i) && $stable(m_adr_i))
    else begin
      fail_count++;
      $error("master request changed before m_ack_i");
    end

  write_data_held: assert property (@(posedge clk_i) disable iff (rst_i)
    m_cyc_i && m_we_i && !m_ack_i |=> $stable(m_wdat_i))
    else begin
      fail_count++;
      $error("write-back data changed before m_ack_i");
    end

  slave_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    s_ack_i |=> !s_ack_i)
    else begin
      fail_count++;
      $error("s_ack_o held for more than one cycle");
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    rst_i |-> !m_cyc_i && !s_ack_i)
    else begin
      fail_count++;
      $error("bus activity during reset");
    end

endmodule

bind cache_top cache_checker u_checker (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .m_cyc_i  (m_cyc_o),
  .m_stb_i  (m_stb_o),
  .m_we_i   (m_we_o),
  .m_adr_i  (m_adr_o),
  .m_wdat_i (m_dat_o),
  .m_ack_i  (m_ack_i),
  .s_ack_i  (s_ack_o)
);

/* testbench/cache_tb.sv */
`timescale 1ns/10ps

module cache_tb;
  import bus_pkg::*;
  import cache_pkg::*;

  localparam int ROW_BITS       = 6;
  localparam int TAG_LSB        = ROW_BITS + WORD_IDX_W;
  localparam int N_TAGS         = 5;
  localparam int N_WIN          = N_TAGS * 16;
  localparam int N_STIM         = 64;
  localparam int N_FIRST        = 8;
  localparam int N_BURST        = 8;
  localparam int N_RANDOM       = 400;
  localparam int N_SWEEP        = 4;
  localparam int NUM_OPS        = N_FIRST + 2 * N_BURST + N_RANDOM + N_SWEEP;
  localparam int TIMEOUT_CYCLES = 2 ** ROW_BITS + NUM_OPS * 80;

  logic  clk_i;
  logic  rst_i;
  logic  s_cyc_i;
  logic  s_stb_i;
  logic  s_we_i;
  adr_t  s_adr_i;
  sel_t  s_sel_i;
  word_t s_dat_i;
  word_t s_dat_o;
  logic  s_ack_o;
  logic  m_cyc_o;
  logic  m_stb_o;
  logic  m_we_o;
  adr_t  m_adr_o;
  word_t m_dat_o;
  word_t m_dat_i;
  logic  m_ack_i;

  // Window index is tag slot * 16 + row * 4 + word
  // Tag slot 4 is only touched by the sweep
  word_t model_mem [N_WIN];
  word_t backing   [N_WIN];
  logic  written   [N_WIN];
  adr_t  pending_q [$];
  string test_name;
  int    cycle_count = 0;
  int    stall_cycles;
  logic  mem_busy;
  int    mem_wait;
  int    fill_word;
  adr_t  fill_base;

  cache_top DUT (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .s_cyc_i (s_cyc_i),
    .s_stb_i (s_stb_i),
    .s_we_i  (s_we_i),
    .s_adr_i (s_adr_i),
    .s_sel_i (s_sel_i),
    .s_dat_i (s_dat_i),
    .s_dat_o (s_dat_o),
    .s_ack_o (s_ack_o),
    .m_cyc_o (m_cyc_o),
    .m_stb_o (m_stb_o),
    .m_we_o  (m_we_o),
    .m_adr_o (m_adr_o),
    .m_dat_o (m_dat_o),
    .m_dat_i (m_dat_i),
    .m_ack_i (m_ack_i)
  );

  function automatic adr_t tag_value(input int slot);
    case (slot)
      0:       return adr_t'(17'h00003);
      1:       return adr_t'(17'h0A5A5);
      2:       return adr_t'(17'h15A5A);
      3:       return adr_t'(17'h1FFFF);
      default: return adr_t'(17'h00C00);
    endcase
  endfunction

  function automatic adr_t win_adr(input int idx);
    adr_t row;
    adr_t word;
    row  = adr_t'((idx / 4) % 4);
    word = adr_t'(idx % 4);
    return (tag_value(idx / 16) << TAG_LSB) | (row << WORD_IDX_W) | word;
  endfunction

  function automatic int win_index(input adr_t adr);
    for (int i = 0; i < N_WIN; i++) begin
      if (win_adr(i) == adr) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic adr_t line_of(input adr_t adr);
    return {adr[ADDR_W-1:WORD_IDX_W], WORD_IDX_W'(0)};
  endfunction

  // An odd multiplier makes every address bit change the word
  function automatic word_t init_pattern(input adr_t adr);
    return (word_t'(adr) * 32'h9E37_79B1) ^ 32'hA5A5_0F0F;
  endfunction

  function automatic word_t apply_sel(input word_t old, input word_t dat, input sel_t sel);
    word_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[b * 8 +: 8] = dat[b * 8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_failure();
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic report_problem(input string what);
    $display("Error in %s: %s", test_name, what);
    report_failure();
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_addr(input string name, input adr_t exp, input adr_t act);
    if (act !== exp) begin
      $display("** Error [%s] expected address %h, actual %h", name, exp, act);
      report_failure();
    end
  endtask

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (DUT.u_checker.fail_count != 0) begin
      report_problem("a bus protocol assertion failed");
    end
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Error: run exceeded %0d cycles, the DUT stopped responding", TIMEOUT_CYCLES);
      report_failure();
    end
  end

  // Fill words must come in order from the line of a queued request
  task automatic check_fill(input adr_t adr);
    logic found;
    if (fill_word == 0) begin
      found = 1'b0;
      while (pending_q.size() > 0 && !found) begin
        if (line_of(pending_q[0]) == line_of(adr)) begin
          found = 1'b1;
        end else begin
          void'(pending_q.pop_front());
        end
      end
      if (!found) begin
        report_problem($sformatf("fill at %h is not in the line of a queued request", adr));
      end
      fill_base = line_of(adr);
    end
    check_addr(test_name, fill_base + adr_t'(fill_word), adr);
    fill_word = (fill_word + 1) % WORDS_PER_LINE;
  endtask

  task automatic serve_master();
    int idx;
    idx = win_index(m_adr_o);
    if (idx < 0) begin
      report_problem($sformatf("master access at %h is outside the test window", m_adr_o));
    end
    if (m_we_o) begin
      if (!written[idx]) begin
        report_problem($sformatf("write-back at %h of a word never written", m_adr_o));
      end
      backing[idx] = m_dat_o;
    end else begin
      check_fill(m_adr_o);
      m_dat_i = backing[idx];
    end
  endtask

  // Memory responder with 0 to 3 wait cycles
  initial begin
    m_ack_i   = 1'b0;
    m_dat_i   = '0;
    mem_busy  = 1'b0;
    mem_wait  = 0;
    fill_word = 0;
    fill_base = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (m_ack_i) begin
        m_ack_i = 1'b0;
        m_dat_i = '0;
      end else if (m_cyc_o) begin
        if (!mem_busy) begin
          mem_busy = 1'b1;
          mem_wait = $urandom_range(3, 0);
        end
        if (mem_wait == 0) begin
          serve_master();
          m_ack_i  = 1'b1;
          mem_busy = 1'b0;
        end else begin
          mem_wait--;
        end
      end
    end
  end

  task automatic next_drive();
    @(posedge clk_i);
    #1;
  endtask

  task automatic release_bus();
    s_cyc_i = 1'b0;
    s_stb_i = 1'b0;
    s_we_i  = 1'b0;
  endtask

  task automatic wait_taken();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      if (s_ack_o) begin
        report_problem("s_ack_o came before the request was taken");
      end
      taken = DUT.fifo_push;
      if (taken) begin
        pending_q.push_back(s_adr_i);
      end else begin
        stall_cycles++;
      end
      next_drive();
    end
  endtask

  task automatic do_write(input int idx, input word_t dat, input sel_t sel);
    s_cyc_i = 1'b1;
    s_stb_i = 1'b1;
    s_we_i  = 1'b1;
    s_adr_i = win_adr(idx);
    s_dat_i = dat;
    s_sel_i = sel;
    wait_taken();
    @(negedge clk_i);
    if (!s_ack_o) begin
      report_problem($sformatf("write to %h not acked one cycle after it was taken", s_adr_i));
    end
    model_mem[idx] = apply_sel(model_mem[idx], dat, sel);
    written[idx]   = 1'b1;
    next_drive();
    release_bus();
  endtask

  task automatic do_read(input adr_t adr, input word_t exp);
    logic got_ack;
    s_cyc_i = 1'b1;
    s_stb_i = 1'b1;
    s_we_i  = 1'b0;
    s_adr_i = adr;
    s_sel_i = '1;
    s_dat_i = '0;
    wait_taken();
    got_ack = 1'b0;
    while (!got_ack) begin
      @(negedge clk_i);
      got_ack = s_ack_o;
      if (!got_ack) begin
        next_drive();
      end
    end
    check_word(test_name, exp, s_dat_o);
    next_drive();
    release_bus();
  endtask

  initial begin
    int    idx;
    word_t dat;
    sel_t  sel;
    void'($urandom(65));
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    s_cyc_i      = 1'b0;
    s_stb_i      = 1'b0;
    s_we_i       = 1'b0;
    s_adr_i      = '0;
    s_sel_i      = '0;
    s_dat_i      = '0;
    stall_cycles = 0;
    test_name    = "reset";
    for (int i = 0; i < N_WIN; i++) begin
      model_mem[i] = init_pattern(win_adr(i));
      backing[i]   = init_pattern(win_adr(i));
      written[i]   = 1'b0;
    end
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    test_name = "first_read";
    for (int k = 0; k < N_FIRST; k++) begin
      idx = $urandom_range(N_STIM - 1, 0);
      do_read(win_adr(idx), init_pattern(win_adr(idx)));
    end

    // Four tags share row 0 so the queue fills behind the misses
    test_name    = "write_burst";
    stall_cycles = 0;
    for (int k = 0; k < N_BURST; k++) begin
      dat = $urandom;
      sel = $urandom_range(15, 1);
      do_write((k % 4) * 16 + k / 4, dat, sel);
    end
    if (stall_cycles == 0) begin
      report_problem("write burst never met a full request FIFO");
    end
    for (int k = 0; k < N_BURST; k++) begin
      idx = (k % 4) * 16 + k / 4;
      do_read(win_adr(idx), model_mem[idx]);
    end

    test_name = "random_mix";
    for (int n = 0; n < N_RANDOM; n++) begin
      idx = $urandom_range(N_STIM - 1, 0);
      if ($urandom_range(1, 0) == 1) begin
        dat = $urandom;
        sel = $urandom_range(15, 0);
        do_write(idx, dat, sel);
      end else begin
        do_read(win_adr(idx), model_mem[idx]);
      end
    end

    // Unused tag evicts every line of the window
    test_name = "evict_sweep";
    for (int r = 0; r < N_SWEEP; r++) begin
      idx = 4 * 16 + r * 4;
      do_read(win_adr(idx), init_pattern(win_adr(idx)));
    end

    test_name = "backing_compare";
    for (int i = 0; i < N_WIN; i++) begin
      check_word($sformatf("%s %h", test_name, win_adr(i)), model_mem[i], backing[i]);
    end

    if (DUT.u_checker.fail_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      report_failure();
    end
  end

endmodule

/* files.f */
rtl/bus_pkg.sv
rtl/cache_pkg.sv
rtl/req_fifo.sv
rtl/line_ram.sv
rtl/line_merge.sv
rtl/slave_port.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
testbench/cache_checker.sv
testbench/cache_tb.sv
